// ==== hw/rf_shell_pkg.sv ====
/*
 * Register file shell package
 * Word widths, interrupt and write-port groups, and the SECDED column rule
 */

package rf_shell_pkg;

  // Named widths of the protected word
  localparam int unsigned EccDataW  = 32;
  localparam int unsigned EccCheckW = 7;

  typedef logic [4:0]                    reg_addr_t;
  typedef logic [EccDataW-1:0]           reg_data_t;
  typedef logic [EccCheckW-1:0]          reg_ecc_t;
  // Check bits on top, data in the low bits
  typedef logic [EccCheckW+EccDataW-1:0] reg_word_t;

  typedef struct packed {
    logic        software;
    logic        timer;
    logic        external;
    logic [14:0] fast;
    logic        nm;
  } irq_t;

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    reg_word_t wdata;
  } rf_wr_t;

  ////////////////////////////////////////////////////////////////////////////
  // SECDED column rule
  ////////////////////////////////////////////////////////////////////////////

  // Data bit idx takes the idx-th 6-bit value with two or more bits set
  function automatic logic [EccCheckW-2:0] ecc_column(int unsigned idx);
    logic [EccCheckW-2:0] col;
    int unsigned          seen;
    col  = '0;
    seen = 0;
    for (int unsigned v = 3; v < 64; v++) begin
      if ($countones(6'(v)) >= 2) begin
        if (seen == idx) begin
          col = 6'(v);
        end
        seen++;
      end
    end
    return col;
  endfunction

endpackage

// ==== hw/sleep_ctrl.sv ====
/*
 * Sleep control
 * Captures fetch enable, registers core busy and gates the core clock
 * with a low-phase latch when nothing needs the core
 */

`timescale 1ns/10ps

module sleep_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  test_en_i,
  input  logic                  fetch_enable_i,
  input  logic                  core_busy_i,
  input  logic                  debug_req_i,
  input  rf_shell_pkg::irq_t    irq_i,
  output logic                  clk_core_o,
  output logic                  core_sleep_o
);

  logic fetch_enable_q;
  logic core_busy_q;
  logic irq_pending;
  logic clock_en;
  logic en_latched;

  ////////////////////////////////////////////////////////////////////////////
  // Control flops on the free-running clock
  ////////////////////////////////////////////////////////////////////////////

  // Set once, held until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // No CSR masking here, any raised line wakes the core
  assign irq_pending = irq_i.software | irq_i.timer | irq_i.external |
                       (|irq_i.fast) | irq_i.nm;

  assign clock_en     = fetch_enable_q & (core_busy_q | debug_req_i | irq_pending);
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////////////////////

  // Transparent while the clock is low, so the enable is stable over the high phase
  always_latch begin
    if (!clk_i) begin
      en_latched <= clock_en | test_en_i;
    end
  end

  assign clk_core_o = clk_i & en_latched;

endmodule

// ==== hw/register_file_ff.sv ====
/*
 * Flip-flop register file
 * Holds 39-bit encoded words, one write port and two read ports
 */

`timescale 1ns/10ps

module register_file_ff #(
  parameter bit RV32E = 1'b0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rf_shell_pkg::rf_wr_t     wr_i,
  input  rf_shell_pkg::reg_addr_t  raddr_a_i,
  input  rf_shell_pkg::reg_addr_t  raddr_b_i,
  output rf_shell_pkg::reg_word_t  rdata_a_o,
  output rf_shell_pkg::reg_word_t  rdata_b_o
);

  localparam int unsigned NumRegs = RV32E ? 16 : 32;

  rf_shell_pkg::reg_word_t rf_reg [32];
  logic [NumRegs-1:1]      we_dec;

  // Write decode, register zero never selected
  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = wr_i.we & (wr_i.waddr == rf_shell_pkg::reg_addr_t'(i));
    end
  end

  assign rf_reg[0] = '0;

  for (genvar i = 1; i < 32; i++) begin : gen_regs
    if (i < NumRegs) begin : gen_ff
      rf_shell_pkg::reg_word_t word_q;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          word_q <= '0;
        end else if (we_dec[i]) begin
          word_q <= wr_i.wdata;
        end
      end

      assign rf_reg[i] = word_q;
    end else begin : gen_absent
      // Upper half does not exist in RV32E
      assign rf_reg[i] = '0;
    end
  end

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

// ==== hw/rf_ecc_check.sv ====
/*
 * SECDED checker for one register file read port
 * Corrects single-bit errors and flags single and double errors
 */

`timescale 1ns/10ps

module rf_ecc_check (
  input  rf_shell_pkg::reg_word_t  rdata_i,
  output rf_shell_pkg::reg_data_t  rdata_o,
  output logic                     err_single_o,
  output logic                     err_double_o
);

  localparam int unsigned DataW  = rf_shell_pkg::EccDataW;
  localparam int unsigned CheckW = rf_shell_pkg::EccCheckW;
  localparam int unsigned SyndW  = CheckW - 1;

  rf_shell_pkg::reg_data_t data;
  rf_shell_pkg::reg_ecc_t  check;
  logic [SyndW-1:0]        contrib [DataW];
  logic [SyndW-1:0]        syndrome;
  logic [DataW-1:0]        flip;
  logic                    parity;
  logic                    syndrome_nz;

  assign data  = rdata_i[DataW-1:0];
  assign check = rdata_i[DataW +: CheckW];

  ////////////////////////////////////////////////////////////////////////////
  // Syndrome
  ////////////////////////////////////////////////////////////////////////////

  // Each data bit folds its column into the recomputed check bits
  for (genvar i = 0; i < DataW; i++) begin : gen_col
    localparam logic [SyndW-1:0] Col = rf_shell_pkg::ecc_column(i);

    assign contrib[i] = Col & {SyndW{data[i]}};
  end

  always_comb begin
    syndrome = check[SyndW-1:0];
    for (int unsigned i = 0; i < DataW; i++) begin
      syndrome = syndrome ^ contrib[i];
    end
  end

  // Whole word has even parity when clean
  assign parity      = ^{check, data};
  assign syndrome_nz = |syndrome;

  ////////////////////////////////////////////////////////////////////////////
  // Correction
  ////////////////////////////////////////////////////////////////////////////

  // Only a data column match flips a bit; check-bit hits leave data alone
  for (genvar i = 0; i < DataW; i++) begin : gen_flip
    localparam logic [SyndW-1:0] Col = rf_shell_pkg::ecc_column(i);

    assign flip[i] = parity & (syndrome == Col);
  end

  assign rdata_o = data ^ flip;

  // Odd parity means one bit flipped
  assign err_single_o = parity;
  assign err_double_o = ~parity & syndrome_nz;

endmodule

// ==== hw/rf_shell_top.sv ====
/*
 * Register file shell top level
 * Sleep control and gated clock, ECC-protected register file, read checks
 */

`timescale 1ns/10ps

module rf_shell_top #(
  parameter bit RV32E = 1'b0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     test_en_i,
  input  logic                     fetch_enable_i,
  input  logic                     core_busy_i,
  input  logic                     debug_req_i,
  input  rf_shell_pkg::irq_t       irq_i,
  input  rf_shell_pkg::rf_wr_t     rf_wr_i,
  input  rf_shell_pkg::reg_addr_t  rf_raddr_a_i,
  input  rf_shell_pkg::reg_addr_t  rf_raddr_b_i,
  output rf_shell_pkg::reg_data_t  rf_rdata_a_o,
  output rf_shell_pkg::reg_data_t  rf_rdata_b_o,
  output logic                     alert_minor_o,
  output logic                     alert_major_o,
  output logic                     core_sleep_o
);

  logic                    clk_core;
  rf_shell_pkg::reg_word_t rdata_a_ecc;
  rf_shell_pkg::reg_word_t rdata_b_ecc;
  logic                    err_single_a, err_single_b;
  logic                    err_double_a, err_double_b;

  sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_en_i      (test_en_i),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .debug_req_i    (debug_req_i),
    .irq_i          (irq_i),
    .clk_core_o     (clk_core),
    .core_sleep_o   (core_sleep_o)
  );

  register_file_ff #(
    .RV32E (RV32E)
  ) u_register_file (
    .clk_i     (clk_core),
    .rst_ni    (rst_ni),
    .wr_i      (rf_wr_i),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .rdata_a_o (rdata_a_ecc),
    .rdata_b_o (rdata_b_ecc)
  );

  rf_ecc_check u_check_a (
    .rdata_i      (rdata_a_ecc),
    .rdata_o      (rf_rdata_a_o),
    .err_single_o (err_single_a),
    .err_double_o (err_double_a)
  );

  rf_ecc_check u_check_b (
    .rdata_i      (rdata_b_ecc),
    .rdata_o      (rf_rdata_b_o),
    .err_single_o (err_single_b),
    .err_double_o (err_double_b)
  );

  assign alert_minor_o = err_single_a | err_single_b;
  assign alert_major_o = err_double_a | err_double_b;

endmodule

// ==== sim/tb_clk_gen.sv ====
/*
 * Testbench clock source, 40 ns period
 */

`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriodNs = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(HalfPeriodNs) clk_o = ~clk_o;

endmodule

// ==== sim/rf_shell_assertions.sv ====
/*
 * Concurrent checks on the shell top level
 * Alert sanity and the sleep rules around fetch enable and busy
 */

`timescale 1ns/10ps

module rf_shell_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic fetch_enable_i,
  input logic core_busy_i,
  input logic core_sleep_o,
  input logic alert_minor_o,
  input logic alert_major_o
);

  logic fetch_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  alerts_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({alert_minor_o, alert_major_o}))
    else $error("alert outputs are unknown");

  // Busy seen at an edge keeps the core awake over the next cycle
  busy_wakes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((fetch_seen_q | fetch_enable_i) & core_busy_i) |=> !core_sleep_o)
    else $error("core asleep although busy after fetch enable");

  asleep_before_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_seen_q |-> core_sleep_o)
    else $error("core awake before fetch enable");

endmodule

bind rf_shell_top rf_shell_assertions u_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .fetch_enable_i (fetch_enable_i),
  .core_busy_i    (core_busy_i),
  .core_sleep_o   (core_sleep_o),
  .alert_minor_o  (alert_minor_o),
  .alert_major_o  (alert_major_o)
);

// ==== sim/tb_rf_shell.sv ====
/*
 * Testbench for the register file shell
 * Random stimulus on falling edges, shadow model and SECDED reference
 */

`timescale 1ns/10ps

module tb_rf_shell;

  localparam int unsigned MaxCycles = 2000;

  logic                    clk;
  logic                    rst_n;
  logic                    test_en;
  logic                    fetch_en;
  logic                    busy;
  logic                    debug;
  rf_shell_pkg::irq_t      irq;
  rf_shell_pkg::rf_wr_t    wr;
  rf_shell_pkg::reg_addr_t raddr_a;
  rf_shell_pkg::reg_addr_t raddr_b;
  rf_shell_pkg::reg_data_t rdata_a;
  rf_shell_pkg::reg_data_t rdata_b;
  logic                    alert_minor;
  logic                    alert_major;
  logic                    core_sleep;

  logic [31:0] seed = 32'he0e3_f664;
  logic [38:0] shadow [32];
  logic        fe_model;
  logic        busy_model;
  logic        wake_low;
  logic        check_en;
  int unsigned cycles;
  int unsigned checks;
  int unsigned errors;
  int unsigned test_errors;
  event        cycle_checked;

  tb_clk_gen u_clk_gen (.clk_o(clk));

  rf_shell_top i_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .test_en_i      (test_en),
    .fetch_enable_i (fetch_en),
    .core_busy_i    (busy),
    .debug_req_i    (debug),
    .irq_i          (irq),
    .rf_wr_i        (wr),
    .rf_raddr_a_i   (raddr_a),
    .rf_raddr_b_i   (raddr_b),
    .rf_rdata_a_o   (rdata_a),
    .rf_rdata_b_o   (rdata_b),
    .alert_minor_o  (alert_minor),
    .alert_major_o  (alert_major),
    .core_sleep_o   (core_sleep)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // idx-th 6-bit value having at least two ones
  function automatic logic [5:0] ref_col(int unsigned idx);
    int unsigned n;
    int unsigned ones;
    n = 0;
    for (int v = 0; v < 64; v++) begin
      ones = 0;
      for (int b = 0; b < 6; b++) begin
        ones += (v >> b) & 1;
      end
      if (ones >= 2) begin
        if (n == idx) begin
          return 6'(v);
        end
        n++;
      end
    end
    return 6'd0;
  endfunction

  function automatic logic [38:0] ref_encode(logic [31:0] d);
    logic [5:0] c;
    c = '0;
    for (int unsigned i = 0; i < 32; i++) begin
      if (d[i]) begin
        c = c ^ ref_col(i);
      end
    end
    return {(^d) ^ (^c), c, d};
  endfunction

  task automatic ref_decode(input logic [38:0] w, output logic [31:0] d,
                            output logic single, output logic double);
    logic [5:0] s;
    logic       p;
    d = w[31:0];
    s = w[37:32];
    p = ^w;
    for (int unsigned i = 0; i < 32; i++) begin
      if (w[i]) begin
        s = s ^ ref_col(i);
      end
    end
    single = p;
    double = !p && (s != 6'd0);
    if (p) begin
      for (int unsigned i = 0; i < 32; i++) begin
        if (s == ref_col(i)) begin
          d[i] = ~d[i];
        end
      end
    end
  endtask

  function automatic logic ref_sleep(logic fe_q, logic busy_q, logic dbg,
                                     rf_shell_pkg::irq_t irqs);
    return !(fe_q && (busy_q || dbg || (|irqs)));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic compare_outputs();
    logic [31:0] da, db;
    logic        sa, sb, xa, xb;
    logic        exp_sleep;
    ref_decode(shadow[raddr_a], da, sa, xa);
    ref_decode(shadow[raddr_b], db, sb, xb);
    exp_sleep = ref_sleep(fe_model, busy_model, debug, irq);
    checks++;
    assert (core_sleep === exp_sleep) else begin
      $display("ERR core_sleep_o got %h exp %h", core_sleep, exp_sleep);
      note_error();
    end
    assert (rdata_a === da) else begin
      $display("ERR rf_rdata_a_o got %h exp %h addr %h", rdata_a, da, raddr_a);
      note_error();
    end
    assert (rdata_b === db) else begin
      $display("ERR rf_rdata_b_o got %h exp %h addr %h", rdata_b, db, raddr_b);
      note_error();
    end
    assert (alert_minor === (sa | sb)) else begin
      $display("ERR alert_minor_o got %h exp %h", alert_minor, sa | sb);
      note_error();
    end
    assert (alert_major === (xa | xb)) else begin
      $display("ERR alert_major_o got %h exp %h", alert_major, xa | xb);
      note_error();
    end
  endtask

  // Model steps at each rising edge and compares late in the cycle
  always @(posedge clk) begin
    wake_low = fe_model && (busy_model || debug || (|irq));
    if (rst_n) begin
      if (wr.we && wake_low && wr.waddr != '0) begin
        shadow[wr.waddr] = wr.wdata;
      end
      if (fetch_en) begin
        fe_model = 1'b1;
      end
      busy_model = busy;
    end
    #15;
    if (check_en) begin
      compare_outputs();
      -> cycle_checked;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive(logic fe, logic bsy, logic dbg, logic [18:0] irqs, logic we,
                       logic [4:0] wa, logic [38:0] wd, logic [4:0] ra, logic [4:0] rb);
    @(negedge clk);
    fetch_en = fe;
    busy     = bsy;
    debug    = dbg;
    irq      = rf_shell_pkg::irq_t'(irqs);
    wr.we    = we;
    wr.waddr = wa;
    wr.wdata = wd;
    raddr_a  = ra;
    raddr_b  = rb;
  endtask

  function automatic logic [18:0] rand_irq();
    logic [31:0] r;
    r = rand32();
    return (r[31:29] == 3'd0) ? r[18:0] : 19'd0;
  endfunction

  // Waits for the check of the last driven cycle before reporting
  task automatic report_test(string name);
    @(cycle_checked);
    $display("Test %s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    test_errors = 0;
  endtask

  // Bad register is read on port a or port b in turn
  task automatic inject_errors(int unsigned nflips);
    logic [31:0] r;
    logic [38:0] w;
    logic [4:0]  wa;
    int unsigned b0, b1;
    for (int k = 0; k < 20; k++) begin
      r  = rand32();
      w  = ref_encode(rand32());
      b0 = r % 39;
      b1 = (b0 + 1 + (rand32() % 38)) % 39;
      w[b0] = ~w[b0];
      if (nflips == 2) begin
        w[b1] = ~w[b1];
      end
      r  = rand32();
      wa = (r[4:0] == '0) ? 5'd1 : r[4:0];
      if (k % 2 == 0) begin
        drive(1'b0, 1'b1, 1'b0, '0, 1'b1, wa, w, wa, 5'd0);
      end else begin
        drive(1'b0, 1'b1, 1'b0, '0, 1'b1, wa, w, 5'd0, wa);
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    rst_n    = 1'b0;
    test_en  = 1'b0;
    check_en = 1'b0;
    fe_model = 1'b0;
    busy_model = 1'b0;
    cycles = 0;
    checks = 0;
    errors = 0;
    test_errors = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    fetch_en = 1'b0;
    busy     = 1'b0;
    debug    = 1'b0;
    irq      = '0;
    wr       = '0;
    raddr_a  = '0;
    raddr_b  = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n    = 1'b1;
    check_en = 1'b1;

    // Writes before fetch enable are lost
    for (int k = 0; k < 12; k++) begin
      r = rand32();
      drive(1'b0, r[0], r[1], rand_irq(), 1'b1, r[12:8], ref_encode(rand32()),
            r[12:8], r[20:16]);
    end
    report_test("sleep_before_fetch");

    drive(1'b1, 1'b0, 1'b0, '0, 1'b0, '0, '0, '0, '0);
    for (int k = 0; k < 100; k++) begin
      r = rand32();
      drive(1'b0, r[0], r[3:1] == 3'd0, rand_irq(), 1'b0, '0, '0, r[12:8], r[20:16]);
    end
    report_test("wake_rule");

    for (int k = 0; k < 200; k++) begin
      r = rand32();
      drive(1'b0, 1'b1, 1'b0, '0, 1'b1, r[4:0], ref_encode(rand32()), r[12:8], r[20:16]);
    end
    report_test("clean_write_read");

    inject_errors(1);
    report_test("single_bit_errors");
    inject_errors(2);
    report_test("double_bit_errors");

    // Core sleeps with all wake sources quiet
    for (int k = 0; k < 6; k++) begin
      r = rand32();
      drive(1'b0, 1'b0, 1'b0, '0, 1'b1, 5'd5, ref_encode(rand32()), 5'd5, r[12:8]);
    end
    report_test("write_while_asleep");

    @(negedge clk);
    check_en = 1'b0;
    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/rf_shell_pkg.sv
hw/sleep_ctrl.sv
hw/register_file_ff.sv
hw/rf_ecc_check.sv
hw/rf_shell_top.sv
sim/tb_clk_gen.sv
sim/rf_shell_assertions.sv
sim/tb_rf_shell.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the register file shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_rf_shell -o sim_rf_shell

out=$(./obj_dir/sim_rf_shell || true)
echo "$out"

# Pass only when the testbench printed its pass line
grep -qx '>>> PASS' <<< "$out"
